/* pu_spi_pkg.sv */
`default_nettype none

package pu_spi_pkg;

    // System word and SPI byte widths
    localparam int DATA_WIDTH     = 32;
    localparam int SPI_DATA_WIDTH = 8;
    localparam int BYTES_PER_WORD = DATA_WIDTH / SPI_DATA_WIDTH;

    // Attribute bus
    localparam int ATTR_WIDTH    = 4;
    localparam int ATTR_VALID    = 0;
    localparam int ATTR_OVERFLOW = 1;

    // Ping-pong bank geometry
    localparam int BUF_SIZE       = 6;
    localparam int BUF_ADDR_WIDTH = 3;

    // One system word, seen whole or as bytes, byte 0 least significant
    typedef union packed {
        logic [DATA_WIDTH-1:0]                         word;
        logic [BYTES_PER_WORD-1:0][SPI_DATA_WIDTH-1:0] bytes;
    } spi_word_u;

endpackage

`default_nettype wire

/* spi_slave_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_driver (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                mosi,
    input  logic                                sclk,
    input  logic                                cs,
    input  logic [pu_spi_pkg::SPI_DATA_WIDTH-1:0] tx_byte,
    output logic                                miso,
    output logic [pu_spi_pkg::SPI_DATA_WIDTH-1:0] rx_byte,
    output logic                                ready,
    output logic                                sel_start,
    output logic                                sel_end
);
    import pu_spi_pkg::*;

    // Two sync flops per pin, plus a history flop on sclk and cs
    logic [2:0] sclk_sr;
    logic [2:0] cs_sr;
    logic [1:0] mosi_sr;

    logic sclk_rise;
    logic sclk_fall;
    logic cs_fall;
    logic cs_rise;
    logic selected;

    logic [$clog2(SPI_DATA_WIDTH)-1:0] bit_cnt;
    logic [SPI_DATA_WIDTH-1:0]         rx_shift;
    logic [SPI_DATA_WIDTH-1:0]         tx_shift;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_sr <= '0;
            cs_sr   <= '1;
            mosi_sr <= '0;
        end else begin
            sclk_sr <= {sclk_sr[1:0], sclk};
            cs_sr   <= {cs_sr[1:0], cs};
            mosi_sr <= {mosi_sr[0], mosi};
        end
    end

    assign selected  = ~cs_sr[1];
    assign sclk_rise = selected & sclk_sr[1] & ~sclk_sr[2];
    assign sclk_fall = selected & ~sclk_sr[1] & sclk_sr[2];
    assign cs_fall   = ~cs_sr[1] & cs_sr[2];
    assign cs_rise   = cs_sr[1] & ~cs_sr[2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt   <= '0;
            ready     <= 1'b0;
            sel_start <= 1'b0;
            sel_end   <= 1'b0;
        end else begin
            sel_start <= cs_fall;
            sel_end   <= cs_rise;
            ready     <= sclk_rise && (bit_cnt == SPI_DATA_WIDTH - 1);
            if (cs_rise) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Mode 0 sampling on the rising edge
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[SPI_DATA_WIDTH-2:0], mosi_sr[1]};
            if (bit_cnt == SPI_DATA_WIDTH - 1) begin
                rx_byte <= {rx_shift[SPI_DATA_WIDTH-2:0], mosi_sr[1]};
            end
        end
    end

    // The falling edge that closes a byte does not shift, as the next byte is already loaded
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_shift <= '0;
        end else if (sel_start || ready) begin
            tx_shift <= tx_byte;
        end else if (sclk_fall && bit_cnt != 0) begin
            tx_shift <= {tx_shift[SPI_DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign miso = tx_shift[SPI_DATA_WIDTH-1];

endmodule

`default_nettype wire

/* spi_pingpong_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_pingpong_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              swap,
    input  logic                              wr,
    input  logic [pu_spi_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic                              rd_next,
    output logic [pu_spi_pkg::DATA_WIDTH-1:0] rd_data,
    output logic [pu_spi_pkg::ATTR_WIDTH-1:0] rd_attr
);
    import pu_spi_pkg::*;

    logic [DATA_WIDTH-1:0] mem [2][BUF_SIZE];

    // fill_sel names the bank being written, the other one is read
    logic                      fill_sel;
    logic                      rd_sel;
    logic [BUF_ADDR_WIDTH-1:0] count [2];
    logic                      ovf [2];
    logic [BUF_ADDR_WIDTH-1:0] rd_ptr;

    logic fill_full;
    logic rd_valid;

    assign rd_sel    = ~fill_sel;
    assign fill_full = (count[fill_sel] == BUF_SIZE);
    assign rd_valid  = (rd_ptr < count[rd_sel]);

    always_ff @(posedge clk) begin
        if (wr && !fill_full) begin
            mem[fill_sel][count[fill_sel]] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_sel <= 1'b0;
            count[0] <= '0;
            count[1] <= '0;
            ovf[0]   <= 1'b0;
            ovf[1]   <= 1'b0;
            rd_ptr   <= '0;
        end else begin
            if (wr) begin
                if (fill_full) begin
                    ovf[fill_sel] <= 1'b1;
                end else begin
                    count[fill_sel] <= count[fill_sel] + 1'b1;
                end
            end

            if (swap) begin
                // Old read bank becomes the empty fill bank
                fill_sel      <= ~fill_sel;
                count[rd_sel] <= '0;
                ovf[rd_sel]   <= 1'b0;
                rd_ptr        <= '0;
            end else if (rd_next && rd_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_comb begin
        rd_attr                = '0;
        rd_attr[ATTR_VALID]    = rd_valid;
        rd_attr[ATTR_OVERFLOW] = ovf[rd_sel];
        if (rd_valid) begin
            rd_data = mem[rd_sel][rd_ptr];
        end else begin
            rd_data = '0;
        end
    end

endmodule

`default_nettype wire

/* spi_word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_word_packer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  ready,
    input  logic [pu_spi_pkg::SPI_DATA_WIDTH-1:0] rx_byte,
    input  logic                                  sel_start,
    input  logic                                  sel_end,
    input  logic [pu_spi_pkg::DATA_WIDTH-1:0]     tx_word,
    input  logic                                  tx_valid,
    output logic [pu_spi_pkg::SPI_DATA_WIDTH-1:0] tx_byte,
    output logic                                  tx_pop,
    output logic [pu_spi_pkg::DATA_WIDTH-1:0]     rx_word,
    output logic                                  rx_push
);
    import pu_spi_pkg::*;

    logic [$clog2(BYTES_PER_WORD)-1:0] byte_cnt;
    logic                              last_byte;

    spi_word_u rx_hold;
    spi_word_u rx_next;
    spi_word_u tx_hold;
    spi_word_u tx_first;

    assign last_byte = (byte_cnt == BYTES_PER_WORD - 1);

    // A new word is needed at the start and at each word boundary
    assign tx_pop = sel_start | (ready & last_byte);

    always_comb begin
        tx_first.word = tx_valid ? tx_word : '0;
        rx_next.bytes = {rx_hold.bytes[BYTES_PER_WORD-2:0], rx_byte};
    end

    // Most significant byte goes out first
    assign tx_byte = tx_pop ? tx_first.bytes[BYTES_PER_WORD-1]
                            : tx_hold.bytes[BYTES_PER_WORD-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
            rx_push  <= 1'b0;
        end else begin
            rx_push <= ready & last_byte;
            if (sel_start || sel_end) begin
                byte_cnt <= '0;
            end else if (ready) begin
                byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            rx_hold <= rx_next;
            if (last_byte) begin
                rx_word <= rx_next.word;
            end
        end
    end

    // First byte leaves with the pop, so the held word is stored one byte ahead
    always_ff @(posedge clk) begin
        if (tx_pop) begin
            tx_hold.word <= tx_first.word << SPI_DATA_WIDTH;
        end else if (ready) begin
            tx_hold.word <= tx_hold.word << SPI_DATA_WIDTH;
        end
    end

endmodule

`default_nettype wire

/* pu_slave_spi.sv */
`timescale 1ns/1ps
`default_nettype none

module pu_slave_spi (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              signal_cycle,

    input  logic                              signal_wr,
    input  logic [pu_spi_pkg::DATA_WIDTH-1:0] data_in,

    input  logic                              signal_oe,
    output logic [pu_spi_pkg::DATA_WIDTH-1:0] data_out,
    output logic [pu_spi_pkg::ATTR_WIDTH-1:0] attr_out,

    output logic                              flag_start,
    output logic                              flag_stop,

    input  logic                              mosi,
    output logic                              miso,
    input  logic                              sclk,
    input  logic                              cs
);
    import pu_spi_pkg::*;

    // Byte level link between driver and packer
    logic [SPI_DATA_WIDTH-1:0] rx_byte;
    logic [SPI_DATA_WIDTH-1:0] tx_byte;
    logic                      spi_ready;

    // Word level link between packer and banks
    logic [DATA_WIDTH-1:0] tx_word;
    logic [ATTR_WIDTH-1:0] tx_attr;
    logic                  tx_pop;
    logic [DATA_WIDTH-1:0] rx_word;
    logic                  rx_push;

    spi_slave_driver spi_driver (
        .clk       (clk),
        .rst       (rst),
        .mosi      (mosi),
        .sclk      (sclk),
        .cs        (cs),
        .tx_byte   (tx_byte),
        .miso      (miso),
        .rx_byte   (rx_byte),
        .ready     (spi_ready),
        .sel_start (flag_start),
        .sel_end   (flag_stop)
    );

    // System writes here, the master reads it next cycle
    spi_pingpong_buffer tx_bank (
        .clk     (clk),
        .rst     (rst),
        .swap    (signal_cycle),
        .wr      (signal_wr),
        .wr_data (data_in),
        .rd_next (tx_pop),
        .rd_data (tx_word),
        .rd_attr (tx_attr)
    );

    // Master writes here, the system reads it next cycle
    spi_pingpong_buffer rx_bank (
        .clk     (clk),
        .rst     (rst),
        .swap    (signal_cycle),
        .wr      (rx_push),
        .wr_data (rx_word),
        .rd_next (signal_oe),
        .rd_data (data_out),
        .rd_attr (attr_out)
    );

    spi_word_packer packer (
        .clk       (clk),
        .rst       (rst),
        .ready     (spi_ready),
        .rx_byte   (rx_byte),
        .sel_start (flag_start),
        .sel_end   (flag_stop),
        .tx_word   (tx_word),
        .tx_valid  (tx_attr[ATTR_VALID]),
        .tx_byte   (tx_byte),
        .tx_pop    (tx_pop),
        .rx_word   (rx_word),
        .rx_push   (rx_push)
    );

endmodule

`default_nettype wire

/* tb_pu_slave_spi.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pu_slave_spi;
    import pu_spi_pkg::*;

    localparam int HALF_SCLK  = 6;
    localparam int WAIT_LIMIT = 200;
    localparam int N_CYCLES   = 10;
    localparam int OVF_CYCLE  = 8;

    logic                  clk;
    logic                  rst;
    logic                  signal_cycle;
    logic                  signal_wr;
    logic [DATA_WIDTH-1:0] data_in;
    logic                  signal_oe;
    logic [DATA_WIDTH-1:0] data_out;
    logic [ATTR_WIDTH-1:0] attr_out;
    logic                  flag_start;
    logic                  flag_stop;
    logic                  mosi;
    logic                  miso;
    logic                  sclk;
    logic                  cs;

    // Reference model, one fill and one read queue per direction
    logic [DATA_WIDTH-1:0] tx_fill_q[$];
    logic [DATA_WIDTH-1:0] tx_read_q[$];
    logic [DATA_WIDTH-1:0] rx_fill_q[$];
    logic [DATA_WIDTH-1:0] rx_read_q[$];
    logic                  rx_fill_ovf;
    logic                  rx_read_ovf;

    logic [SPI_DATA_WIDTH-1:0] mosi_bytes[$];
    logic [SPI_DATA_WIDTH-1:0] miso_bytes[$];

    logic [31:0] lcg_state;
    int          n_start;
    int          n_stop;
    int          n_xfer;

    pu_slave_spi dut0 (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .data_in      (data_in),
        .signal_oe    (signal_oe),
        .data_out     (data_out),
        .attr_out     (attr_out),
        .flag_start   (flag_start),
        .flag_stop    (flag_stop),
        .mosi         (mosi),
        .miso         (miso),
        .sclk         (sclk),
        .cs           (cs)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            if (flag_start) begin
                n_start = n_start + 1;
            end
            if (flag_stop) begin
                n_stop = n_stop + 1;
            end
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:16], lo[31:16]};
    endfunction

    // Next word the master should see, zero once the bank runs dry
    function automatic logic [DATA_WIDTH-1:0] pop_tx_model();
        if (tx_read_q.size() > 0) begin
            return tx_read_q.pop_front();
        end
        return '0;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_word(input string what, input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] expected);
        assert (got === expected) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic check_read_side(input logic valid, input logic [DATA_WIDTH-1:0] word);
        logic [ATTR_WIDTH-1:0] exp_attr;
        exp_attr                = '0;
        exp_attr[ATTR_VALID]    = valid;
        exp_attr[ATTR_OVERFLOW] = rx_read_ovf;
        compare_word("attr_out", DATA_WIDTH'(attr_out), DATA_WIDTH'(exp_attr));
        compare_word("data_out", data_out, word);
    endtask

    task automatic write_words(input int n);
        logic [DATA_WIDTH-1:0] w;
        int i;
        for (i = 0; i < n; i++) begin
            w = random_word();
            @(posedge clk);
            signal_wr <= 1'b1;
            data_in   <= w;
            if (tx_fill_q.size() < BUF_SIZE) begin
                tx_fill_q.push_back(w);
            end
        end
        @(posedge clk);
        signal_wr <= 1'b0;
    endtask

    task automatic read_words();
        int i;
        int n;
        n = rx_read_q.size();
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            check_read_side(1'b1, rx_read_q.pop_front());
            signal_oe <= 1'b1;
            @(posedge clk);
            signal_oe <= 1'b0;
        end
        // Past the end, and one more strobe must not change that
        @(posedge clk);
        check_read_side(1'b0, '0);
        signal_oe <= 1'b1;
        @(posedge clk);
        signal_oe <= 1'b0;
        @(posedge clk);
        check_read_side(1'b0, '0);
    endtask

    task automatic pulse_cycle();
        @(posedge clk);
        signal_cycle <= 1'b1;
        @(posedge clk);
        signal_cycle <= 1'b0;
        tx_read_q = tx_fill_q;
        tx_fill_q.delete();
        rx_read_q   = rx_fill_q;
        rx_read_ovf = rx_fill_ovf;
        rx_fill_q.delete();
        rx_fill_ovf = 1'b0;
    endtask

    // Mode 0 master, mosi set on the falling edge, miso taken on the rising edge
    task automatic master_transfer(input int nbytes);
        logic [SPI_DATA_WIDTH-1:0] tx_b;
        logic [SPI_DATA_WIDTH-1:0] rx_b;
        logic [SPI_DATA_WIDTH-1:0] next_b;
        int b;
        int k;
        int t;
        miso_bytes.delete();
        tx_b = mosi_bytes[0];
        @(posedge clk);
        cs   <= 1'b0;
        mosi <= tx_b[SPI_DATA_WIDTH-1];
        t = 0;
        while (!flag_start) begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                $display("Timeout: no flag_start pulse after cs went low");
                abort_run();
            end
        end
        for (b = 0; b < nbytes; b++) begin
            tx_b = mosi_bytes[b];
            next_b = (b + 1 < nbytes) ? mosi_bytes[b+1] : '0;
            rx_b = '0;
            for (k = SPI_DATA_WIDTH - 1; k >= 0; k--) begin
                repeat (HALF_SCLK) @(posedge clk);
                rx_b[k] = miso;
                sclk <= 1'b1;
                repeat (HALF_SCLK) @(posedge clk);
                sclk <= 1'b0;
                mosi <= (k > 0) ? tx_b[k-1] : next_b[SPI_DATA_WIDTH-1];
            end
            miso_bytes.push_back(rx_b);
        end
        repeat (HALF_SCLK) @(posedge clk);
        cs <= 1'b1;
        t = 0;
        while (!flag_stop) begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                $display("Timeout: no flag_stop pulse after cs went high");
                abort_run();
            end
        end
        n_xfer++;
        repeat (2) @(posedge clk);
        assert (n_start == n_xfer && n_stop == n_xfer) else begin
            $display("** Error at %0t ns: %0d transactions gave %0d flag_start and %0d flag_stop",
                     $time, n_xfer, n_start, n_stop);
            abort_run();
        end
    endtask

    task automatic run_transaction(input int nwords, input int extra);
        logic [DATA_WIDTH-1:0] w;
        logic [DATA_WIDTH-1:0] expected;
        logic [31:0]           r;
        int i;
        int j;
        mosi_bytes.delete();
        for (i = 0; i < nwords; i++) begin
            w = random_word();
            for (j = BYTES_PER_WORD - 1; j >= 0; j--) begin
                mosi_bytes.push_back(w[j*SPI_DATA_WIDTH +: SPI_DATA_WIDTH]);
            end
            if (rx_fill_q.size() < BUF_SIZE) begin
                rx_fill_q.push_back(w);
            end else begin
                rx_fill_ovf = 1'b1;
            end
        end
        // Trailing bytes of a partial word, never stored
        for (j = 0; j < extra; j++) begin
            r = next_random();
            mosi_bytes.push_back(r[31:24]);
        end
        master_transfer(nwords * BYTES_PER_WORD + extra);

        // One word taken at the start and one after each full word
        expected = pop_tx_model();
        for (i = 0; i < nwords; i++) begin
            w = '0;
            for (j = 0; j < BYTES_PER_WORD; j++) begin
                w = {w[DATA_WIDTH-SPI_DATA_WIDTH-1:0], miso_bytes[i*BYTES_PER_WORD+j]};
            end
            compare_word("miso word", w, expected);
            expected = pop_tx_model();
        end
        for (j = 0; j < extra; j++) begin
            compare_word("miso byte", DATA_WIDTH'(miso_bytes[nwords*BYTES_PER_WORD+j]),
                         DATA_WIDTH'(expected[DATA_WIDTH-1-j*SPI_DATA_WIDTH -: SPI_DATA_WIDTH]));
        end
    endtask

    initial begin
        int cyc;
        int x;
        int n_wr;
        int n_tr;
        clk          = 1'b0;
        rst          = 1'b1;
        signal_cycle = 1'b0;
        signal_wr    = 1'b0;
        data_in      = '0;
        signal_oe    = 1'b0;
        mosi         = 1'b0;
        sclk         = 1'b0;
        cs           = 1'b1;
        lcg_state    = 32'd55854;
        n_start      = 0;
        n_stop       = 0;
        n_xfer       = 0;
        rx_fill_ovf  = 1'b0;
        rx_read_ovf  = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Idle bus, nothing to read and no flags
        repeat (20) @(posedge clk);
        check_read_side(1'b0, '0);
        compare_word("flag pulses while idle", DATA_WIDTH'(n_start + n_stop), '0);

        for (cyc = 0; cyc < N_CYCLES; cyc++) begin
            n_wr = (cyc == OVF_CYCLE) ? BUF_SIZE + 2 : random_below(BUF_SIZE + 1);
            n_tr = (cyc == OVF_CYCLE) ? 1 : 1 + random_below(2);
            write_words(n_wr);
            read_words();
            pulse_cycle();
            for (x = 0; x < n_tr; x++) begin
                if (cyc == OVF_CYCLE) begin
                    run_transaction(BUF_SIZE + 2, 0);
                end else begin
                    run_transaction(1 + random_below(BUF_SIZE + 1), random_below(BYTES_PER_WORD));
                end
            end
        end
        read_words();
        pulse_cycle();
        read_words();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
pu_spi_pkg.sv
spi_slave_driver.sv
spi_pingpong_buffer.sv
spi_word_packer.sv
pu_slave_spi.sv
tb_pu_slave_spi.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pu_slave_spi -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pu_slave_spi > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
